// ==== hdl/camera_spi_config.svh ====
/*
 * Build-time sizing for the camera SPI control path.
 * Include this wherever the buffer depth, the credit count or the reset
 * zoom value is needed.
 */
`ifndef CAMERA_SPI_CONFIG_SVH
`define CAMERA_SPI_CONFIG_SVH

// Frame store size in bytes
// Must stay below 65536 for the 16-bit size registers
`define IMAGE_BUFFER_DEPTH 4096

// Memory index width for the frame store
`define IMAGE_ADDRESS_WIDTH $clog2(`IMAGE_BUFFER_DEPTH)

// Credits held by the encoder after reset
// Same value sets the input FIFO depth
`define ENCODER_CREDIT_LIMIT 4

// Zoom setting applied at reset
`define RESET_HALF_RESOLUTION 256

`endif

// ==== hdl/camera_spi_pkg.sv ====
/*
 * Op-codes and bundled signal types for the camera SPI control path.
 * Shared by the RTL and the testbench.
 */
package camera_spi_pkg;

    // Host op-codes, first byte of every transaction
    typedef enum logic [7:0] {
        OP_CAPTURE         = 8'h20,
        OP_BYTES_AVAILABLE = 8'h21,
        OP_READ_DATA       = 8'h22,
        OP_ZOOM            = 8'h23,
        OP_METERING        = 8'h25,
        OP_COMPRESSION     = 8'h26,
        OP_IMAGE_READY     = 8'h27,
        OP_POWER_SAVE      = 8'h28
    } op_code_t;

    // Deframed SPI transaction state
    typedef struct packed {
        op_code_t   op_code;
        logic       op_code_valid;
        logic [7:0] operand;
        logic       operand_valid;
        // Operand bytes completed so far
        logic [7:0] operand_count;
    } spi_command_t;

    typedef struct packed {
        logic [7:0] red_center;
        logic [7:0] green_center;
        logic [7:0] blue_center;
        logic [7:0] red_average;
        logic [7:0] green_average;
        logic [7:0] blue_average;
    } metering_t;

    typedef struct packed {
        logic       start_capture;
        logic [9:0] half_resolution;
        logic [1:0] compression_factor;
        logic       power_save_enable;
    } camera_control_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
    } encoder_byte_t;

    typedef struct packed {
        logic        image_ready;
        logic [15:0] total_size;
    } image_status_t;

endpackage

// ==== hdl/spi_peripheral.sv ====
/*
 * SPI mode 0 peripheral for the camera host link.
 * Oversamples the pins, splits each transaction into an op-code byte and
 * operand bytes, and shifts the register block's response out MSB first.
 */
module spi_peripheral (
    input  logic                        clock_in,
    input  logic                        reset_n_in,

    input  logic                        sck,
    input  logic                        cs_n,
    input  logic                        copi,
    output logic                        cipo,

    output camera_spi_pkg::spi_command_t command,
    input  logic [7:0]                  response
);

    import camera_spi_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] copi_sync;
    logic       sck_prev;

    logic       sck_rise;
    logic       sck_fall;
    logic       selected;

    logic [2:0] bit_count;
    logic [6:0] shift_in;
    logic [7:0] received_byte;
    logic [7:0] shift_out;

    // Two-flop synchronisers plus one stage for edge detection
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;
            copi_sync <= 2'b00;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs_n};
            copi_sync <= {copi_sync[0], copi};
            sck_prev  <= sck_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign sck_fall = ~sck_sync[1] & sck_prev;
    assign selected = ~cs_sync[1];

    // Byte as it stands once the current bit is taken in
    assign received_byte = {shift_in, copi_sync[1]};

    // Receive side and byte framing
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            bit_count <= 3'd0;
            shift_in  <= 7'd0;
            command   <= '0;
        end else if (!selected) begin
            // Chip select high closes the transaction
            bit_count               <= 3'd0;
            command.op_code_valid   <= 1'b0;
            command.operand_valid   <= 1'b0;
            command.operand_count   <= 8'd0;
        end else if (sck_rise) begin
            shift_in  <= received_byte[6:0];
            bit_count <= bit_count + 3'd1;

            // First edge of a new byte retires the previous operand
            if (bit_count == 3'd0) begin
                command.operand_valid <= 1'b0;
            end

            if (bit_count == 3'd7) begin
                if (!command.op_code_valid) begin
                    command.op_code       <= op_code_t'(received_byte);
                    command.op_code_valid <= 1'b1;
                end else begin
                    command.operand       <= received_byte;
                    command.operand_valid <= 1'b1;
                    command.operand_count <= command.operand_count + 8'd1;
                end
            end
        end
    end

    // Transmit side changes on the falling edge of sck
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            shift_out <= 8'd0;
        end else if (!selected) begin
            shift_out <= 8'd0;
        end else if (sck_fall) begin
            if (bit_count == 3'd0) begin
                // Next response is taken at the byte boundary
                shift_out <= response;
            end else begin
                shift_out <= {shift_out[6:0], 1'b0};
            end
        end
    end

    assign cipo = shift_out[7];

endmodule

// ==== hdl/spi_registers.sv ====
/*
 * Op-code decoder for the camera control path.
 * Drives the camera controls from host writes, builds the response byte
 * for status, metering and image reads, and walks the image read address.
 */
`include "camera_spi_config.svh"

module spi_registers (
    input  logic                           clock_in,
    input  logic                           reset_n_in,

    input  camera_spi_pkg::spi_command_t    command,
    output logic [7:0]                     response,

    output camera_spi_pkg::camera_control_t control,

    input  camera_spi_pkg::image_status_t   image_status,
    input  logic [7:0]                     image_data,
    output logic [15:0]                    image_address,

    input  camera_spi_pkg::metering_t       metering
);

    import camera_spi_pkg::*;

    logic [15:0] bytes_remaining;
    logic        operand_valid_prev;
    logic        op_code_valid_prev;
    logic        operand_valid_rise;
    logic        transaction_start;

    assign bytes_remaining    = image_status.total_size - image_address;
    assign operand_valid_rise = command.operand_valid & ~operand_valid_prev;
    assign transaction_start  = command.op_code_valid & ~op_code_valid_prev;

    // Operand writes use count - 1 since the count has already advanced
    // by the time operand_valid is seen
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            response                   <= 8'd0;
            control.start_capture      <= 1'b0;
            control.half_resolution    <= 10'(`RESET_HALF_RESOLUTION);
            control.compression_factor <= 2'd0;
            control.power_save_enable  <= 1'b0;
            image_address              <= 16'd0;
            operand_valid_prev         <= 1'b0;
            op_code_valid_prev         <= 1'b0;
        end else begin
            operand_valid_prev    <= command.operand_valid;
            op_code_valid_prev    <= command.op_code_valid;
            control.start_capture <= 1'b0;

            if (command.op_code_valid) begin
                case (command.op_code)
                    OP_CAPTURE: begin
                        // One pulse per transaction
                        if (transaction_start) begin
                            control.start_capture <= 1'b1;
                            image_address         <= 16'd0;
                        end
                    end

                    OP_BYTES_AVAILABLE: begin
                        case (command.operand_count)
                            8'd0:    response <= bytes_remaining[15:8];
                            8'd1:    response <= bytes_remaining[7:0];
                            default: response <= 8'd0;
                        endcase
                    end

                    OP_READ_DATA: begin
                        response <= image_data;
                        // Address parks at the end of the frame
                        if (operand_valid_rise &&
                            image_address < image_status.total_size) begin
                            image_address <= image_address + 16'd1;
                        end
                    end

                    OP_ZOOM: begin
                        if (command.operand_valid) begin
                            case (command.operand_count)
                                8'd1: begin
                                    control.half_resolution <=
                                        {command.operand[1:0], 8'h00};
                                end
                                8'd2: begin
                                    control.half_resolution[7:0] <= command.operand;
                                end
                                default: ;
                            endcase
                        end
                    end

                    OP_METERING: begin
                        case (command.operand_count)
                            8'd0:    response <= metering.red_center;
                            8'd1:    response <= metering.green_center;
                            8'd2:    response <= metering.blue_center;
                            8'd3:    response <= metering.red_average;
                            8'd4:    response <= metering.green_average;
                            8'd5:    response <= metering.blue_average;
                            default: response <= 8'd0;
                        endcase
                    end

                    OP_COMPRESSION: begin
                        if (command.operand_valid) begin
                            control.compression_factor <= command.operand[1:0];
                        end
                    end

                    OP_IMAGE_READY: begin
                        response <= {7'd0, image_status.image_ready};
                    end

                    OP_POWER_SAVE: begin
                        if (command.operand_valid) begin
                            control.power_save_enable <= command.operand[0];
                        end
                    end

                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/image_buffer.sv ====
/*
 * Single-frame store for the compressed image.
 * Encoder bytes enter a small credit-controlled FIFO and drain into the
 * frame memory; the host side reads it back through a registered port.
 */
`include "camera_spi_config.svh"

module image_buffer (
    input  logic                          clock_in,
    input  logic                          reset_n_in,

    input  camera_spi_pkg::encoder_byte_t  encoder,
    output logic                          credit_return,

    input  logic                          start_capture,
    input  logic [15:0]                   read_address,
    output logic [7:0]                    read_data,
    output camera_spi_pkg::image_status_t  status
);

    localparam int FIFO_DEPTH    = `ENCODER_CREDIT_LIMIT;
    localparam int POINTER_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH   = $clog2(FIFO_DEPTH + 1);
    localparam int ADDRESS_WIDTH = `IMAGE_ADDRESS_WIDTH;
    localparam logic [15:0] DEPTH_LIMIT = 16'(`IMAGE_BUFFER_DEPTH);

    logic [7:0]               fifo_data [0:FIFO_DEPTH-1];
    logic                     fifo_last [0:FIFO_DEPTH-1];
    logic [POINTER_WIDTH-1:0] write_ptr;
    logic [POINTER_WIDTH-1:0] read_ptr;
    logic [COUNT_WIDTH-1:0]   fifo_count;
    logic                     fifo_pop;

    logic [7:0]  frame_memory [0:`IMAGE_BUFFER_DEPTH-1];
    logic [15:0] write_count;
    logic [15:0] read_index;
    logic        capturing;
    logic        in_range;
    logic        store_byte;

    // One byte leaves the FIFO every cycle it holds anything
    assign fifo_pop   = (fifo_count != '0);
    assign in_range   = (write_count < DEPTH_LIMIT);
    assign store_byte = fifo_pop & capturing & ~start_capture & in_range;

    // Reads past the end of the frame return its final byte
    assign read_index = (read_address < status.total_size) ?
                        read_address : status.total_size - 16'd1;

    always_ff @(posedge clock_in) begin
        if (encoder.valid) begin
            fifo_data[write_ptr] <= encoder.data;
            fifo_last[write_ptr] <= encoder.last;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            write_ptr     <= '0;
            read_ptr      <= '0;
            fifo_count    <= '0;
            credit_return <= 1'b0;
            capturing     <= 1'b0;
            write_count   <= 16'd0;
            status        <= '0;
        end else begin
            if (encoder.valid) begin
                write_ptr <= (write_ptr == POINTER_WIDTH'(FIFO_DEPTH - 1)) ?
                             '0 : write_ptr + 1'b1;
            end
            if (fifo_pop) begin
                read_ptr <= (read_ptr == POINTER_WIDTH'(FIFO_DEPTH - 1)) ?
                            '0 : read_ptr + 1'b1;
            end
            case ({encoder.valid, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase

            // Credit goes back whether or not the byte was kept
            credit_return <= fifo_pop;

            if (start_capture) begin
                capturing          <= 1'b1;
                write_count        <= 16'd0;
                status.image_ready <= 1'b0;
            end else if (fifo_pop && capturing) begin
                if (in_range) begin
                    write_count <= write_count + 16'd1;
                end
                if (fifo_last[read_ptr]) begin
                    capturing          <= 1'b0;
                    status.image_ready <= 1'b1;
                    status.total_size  <= write_count + {15'd0, in_range};
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (store_byte) begin
            frame_memory[write_count[ADDRESS_WIDTH-1:0]] <= fifo_data[read_ptr];
        end
        read_data <= frame_memory[read_index[ADDRESS_WIDTH-1:0]];
    end

endmodule

// ==== hdl/camera_spi_top.sv ====
/*
 * Camera SPI control path.
 * Joins the SPI byte layer, the op-code register block and the frame
 * buffer fed by the upstream encoder.
 */
module camera_spi_top (
    input  logic                           clock_in,
    input  logic                           reset_n_in,

    // Host SPI pins
    input  logic                           sck,
    input  logic                           cs_n,
    input  logic                           copi,
    output logic                           cipo,

    // Encoder link with credit return
    input  camera_spi_pkg::encoder_byte_t   encoder,
    output logic                           credit_return,

    input  camera_spi_pkg::metering_t       metering,
    output camera_spi_pkg::camera_control_t control
);

    import camera_spi_pkg::*;

    spi_command_t  command;
    logic [7:0]    response;
    image_status_t image_status;
    logic [7:0]    image_data;
    logic [15:0]   image_address;

    spi_peripheral spi_peripheral (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .sck        (sck),
        .cs_n       (cs_n),
        .copi       (copi),
        .cipo       (cipo),
        .command    (command),
        .response   (response)
    );

    spi_registers spi_registers (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .command       (command),
        .response      (response),
        .control       (control),
        .image_status  (image_status),
        .image_data    (image_data),
        .image_address (image_address),
        .metering      (metering)
    );

    image_buffer image_buffer (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .encoder       (encoder),
        .credit_return (credit_return),
        .start_capture (control.start_capture),
        .read_address  (image_address),
        .read_data     (image_data),
        .status        (image_status)
    );

endmodule

// ==== tb/clock_gen.sv ====
/*
 * Free-running clock for the camera SPI testbench.
 * The period is a parameter, 4 time units by default.
 */
module clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #(PERIOD / 2) clock = ~clock;

endmodule

// ==== tb/camera_spi_props.sv ====
/*
 * Concurrent checks on the camera SPI top level, attached with bind.
 * Covers the reset state of the outputs and the encoder credit loop.
 */
`include "camera_spi_config.svh"

module camera_spi_props (
    input  logic                            clock_in,
    input  logic                            reset_n_in,
    input  logic                            cipo,
    input  camera_spi_pkg::encoder_byte_t   encoder,
    input  logic                            credit_return,
    input  camera_spi_pkg::camera_control_t control
);

    import camera_spi_pkg::*;

    localparam int CREDIT_LIMIT = `ENCODER_CREDIT_LIMIT;

    // Bytes sent by the encoder and not yet credited back
    int outstanding;
    int assertion_failures = 0;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(encoder.valid) - int'(credit_return);
        end
    end

    reset_values: assert property (@(posedge clock_in) $rose(reset_n_in) |->
        (!control.start_capture && !control.power_save_enable &&
         control.half_resolution == 10'(`RESET_HALF_RESOLUTION) &&
         control.compression_factor == 2'd0 && !cipo && !credit_return))
    else begin
        $error("Outputs do not hold their reset values when reset is released");
        assertion_failures++;
    end

    send_needs_credit: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        encoder.valid |-> outstanding < CREDIT_LIMIT)
    else begin
        $error("Encoder sent a byte without a credit");
        assertion_failures++;
    end

    credit_needs_byte: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        credit_return |-> outstanding > 0)
    else begin
        $error("Credit returned with no byte outstanding");
        assertion_failures++;
    end

    // Capture start is a single-cycle pulse
    capture_pulse: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        control.start_capture |=> !control.start_capture)
    else begin
        $error("start_capture stayed high for more than one cycle");
        assertion_failures++;
    end

endmodule

// ==== tb/camera_spi_tb.sv ====
/*
 * Testbench for the camera SPI control path.
 * Models the SPI host at clock_in / 8 and a credit-aware encoder, and
 * runs the control, metering, capture and read-back tests.
 */
`include "camera_spi_config.svh"

module camera_spi_tb;

    import camera_spi_pkg::*;

    localparam int CREDIT_LIMIT = `ENCODER_CREDIT_LIMIT;
    localparam int FRAME_BYTES  = 24;

    logic            clock_in;
    logic            reset_n_in;
    logic            sck;
    logic            cs_n;
    logic            copi;
    logic            cipo;
    encoder_byte_t   encoder;
    logic            credit_return;
    metering_t       metering;
    camera_control_t control;

    logic [7:0] tx_queue[$];
    logic [7:0] rx_queue[$];
    logic [7:0] expected_frame[$];

    integer seed = 32'h3d7b;
    int     bytes_sent = 0;
    int     credits_returned = 0;
    int     checks = 0;
    int     failures = 0;
    int     test_checks = 0;
    int     test_failures = 0;

    clock_gen #(.PERIOD(4)) clock_source (.clock(clock_in));

    camera_spi_top UUT (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .sck           (sck),
        .cs_n          (cs_n),
        .copi          (copi),
        .cipo          (cipo),
        .encoder       (encoder),
        .credit_return (credit_return),
        .metering      (metering),
        .control       (control)
    );

    bind camera_spi_top camera_spi_props props (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .cipo          (cipo),
        .encoder       (encoder),
        .credit_return (credit_return),
        .control       (control)
    );

    // Credit pulses as the encoder model sees them
    always @(negedge clock_in) begin
        if (credit_return) begin
            credits_returned <= credits_returned + 1;
        end
    end

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        test_checks++;
        assert (got === expected) else begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, expected, got);
            test_failures++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d failures", name, test_checks, test_failures);
        checks += test_checks;
        failures += test_failures;
        test_checks = 0;
        test_failures = 0;
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    // Sends one byte MSB first and samples cipo just before each rising sck
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            sck  = 1'b0;
            copi = tx[i];
            repeat (4) @(negedge clock_in);
            rx  = {rx[6:0], cipo};
            sck = 1'b1;
            repeat (4) @(negedge clock_in);
        end
    endtask

    // Sends the op-code and then every byte in tx_queue with replies in rx_queue
    task automatic spi_transaction(input op_code_t op);
        logic [7:0] reply;
        rx_queue.delete();
        cs_n = 1'b0;
        repeat (4) @(negedge clock_in);
        spi_byte(op, reply);
        foreach (tx_queue[i]) begin
            spi_byte(tx_queue[i], reply);
            rx_queue.push_back(reply);
        end
        sck = 1'b0;
        repeat (4) @(negedge clock_in);
        cs_n = 1'b1;
        repeat (8) @(negedge clock_in);
        tx_queue.delete();
    endtask

    task automatic send_frame(input int count);
        logic [7:0] value;
        int         waited;
        expected_frame.delete();
        for (int k = 0; k < count; k++) begin
            value  = 8'($random(seed));
            waited = 0;
            while (bytes_sent - credits_returned >= CREDIT_LIMIT) begin
                if (waited == 100) report_timeout("an encoder credit");
                waited++;
                encoder = '0;
                @(negedge clock_in);
            end
            encoder.data  = value;
            encoder.valid = 1'b1;
            encoder.last  = (k == count - 1);
            bytes_sent++;
            expected_frame.push_back(value);
            @(negedge clock_in);
        end
        encoder = '0;
    endtask

    initial begin
        logic [7:0] zoom_high;
        logic [7:0] zoom_low;
        logic [7:0] setting;
        logic       ready;
        int         attempts;

        reset_n_in = 1'b0;
        sck        = 1'b0;
        cs_n       = 1'b1;
        copi       = 1'b0;
        encoder    = '0;
        metering   = '0;
        // Every metering byte drawn on its own
        for (int k = 0; k < 6; k++) begin
            metering[8 * k +: 8] = 8'($random(seed));
        end
        repeat (16) @(negedge clock_in);
        reset_n_in = 1'b1;
        repeat (4) @(negedge clock_in);
        finish_test("reset");

        // Zoom is written high byte first
        zoom_high = 8'($random(seed));
        zoom_low  = 8'($random(seed));
        tx_queue  = '{zoom_high, zoom_low};
        spi_transaction(OP_ZOOM);
        compare_value("half_resolution", control.half_resolution, {zoom_high[1:0], zoom_low});
        // Low bits kept nonzero so the write differs from the reset value
        setting = 8'($random(seed)) | 8'h01;
        tx_queue.push_back(setting);
        spi_transaction(OP_COMPRESSION);
        compare_value("compression_factor", control.compression_factor, setting[1:0]);
        tx_queue.push_back(8'h01);
        spi_transaction(OP_POWER_SAVE);
        compare_value("power_save_enable", control.power_save_enable, 1'b1);
        finish_test("controls");

        tx_queue = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        spi_transaction(OP_METERING);
        for (int k = 0; k < 6; k++) begin
            compare_value("metering byte", rx_queue[k], metering[47 - 8 * k -: 8]);
        end
        finish_test("metering");

        spi_transaction(OP_CAPTURE);
        send_frame(FRAME_BYTES);
        ready    = 1'b0;
        attempts = 0;
        while (!ready) begin
            if (attempts == 50) report_timeout("image ready");
            attempts++;
            tx_queue.push_back(8'h00);
            spi_transaction(OP_IMAGE_READY);
            ready = rx_queue[0][0];
        end
        compare_value("image ready response", rx_queue[0], 8'h01);
        attempts = 0;
        while (credits_returned != bytes_sent) begin
            if (attempts == 100) report_timeout("the last credit returns");
            attempts++;
            @(negedge clock_in);
        end
        tx_queue = '{8'h00, 8'h00};
        spi_transaction(OP_BYTES_AVAILABLE);
        compare_value("bytes available", {rx_queue[0], rx_queue[1]}, 16'(FRAME_BYTES));
        finish_test("capture");

        // Two reads past the end repeat the final byte
        for (int k = 0; k < FRAME_BYTES + 2; k++) begin
            tx_queue.push_back(8'h00);
        end
        spi_transaction(OP_READ_DATA);
        for (int k = 0; k < FRAME_BYTES + 2; k++) begin
            compare_value("image byte", rx_queue[k],
                          expected_frame[(k < FRAME_BYTES) ? k : FRAME_BYTES - 1]);
        end
        tx_queue = '{8'h00, 8'h00};
        spi_transaction(OP_BYTES_AVAILABLE);
        compare_value("bytes available after read", {rx_queue[0], rx_queue[1]}, 16'd0);
        finish_test("read back");

        $display("summary: %0d checks, %0d failures, %0d assertion failures",
                 checks, failures, UUT.props.assertion_failures);
        if (failures == 0 && UUT.props.assertion_failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/camera_spi_pkg.sv
hdl/spi_peripheral.sv
hdl/spi_registers.sv
hdl/image_buffer.sv
hdl/camera_spi_top.sv
tb/clock_gen.sv
tb/camera_spi_props.sv
tb/camera_spi_tb.sv

// ==== Bender.yml ====
package:
  name: camera_spi

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/camera_spi_pkg.sv
      - hdl/spi_peripheral.sv
      - hdl/spi_registers.sv
      - hdl/image_buffer.sv
      - hdl/camera_spi_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/clock_gen.sv
      - tb/camera_spi_props.sv
      - tb/camera_spi_tb.sv
